//--- Bender.yml
package:
  name: fetch_engine

sources:
  # design, package first
  - files:
      - hdl/engine_pkg.sv
      - hdl/pc_fifo.sv
      - hdl/window_arbiter.sv
      - hdl/latency_counter.sv
      - hdl/fetch_sequencer.sv
      - hdl/instr_select.sv
      - hdl/fetch_engine.sv

  # testbench with the included memory model
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_fetch_engine.sv

//--- fetch_engine.f
+incdir+test
hdl/engine_pkg.sv
hdl/pc_fifo.sv
hdl/window_arbiter.sv
hdl/latency_counter.sv
hdl/fetch_sequencer.sv
hdl/instr_select.sv
hdl/fetch_engine.sv
test/tb_fetch_engine.sv

//--- hdl/engine_pkg.sv
////////////////////////////////////////////////////////////
// sizes and shared types of the fetch engine
// program counter entries, memory words, masks
////////////////////////////////////////////////////////////

package engine_pkg;

    ////////////////////////////////////////////////////////////
    // sizes
    ////////////////////////////////////////////////////////////

    // program counter and character window id
    localparam int PC_WIDTH         = 8;
    localparam int CC_ID_BITS       = 2;
    localparam int N_CHARS          = 4;

    // instruction memory with four 16-bit slots per 64-bit word
    localparam int INSTR_WIDTH      = 16;
    localparam int MEM_WIDTH        = 64;
    localparam int OFFSET_BITS      = 2;
    localparam int MEM_ADDR_WIDTH   = 6;

    // per-window queues and the occupancy count
    localparam int FIFO_DEPTH       = 16;
    localparam int FIFO_COUNT_WIDTH = 5;
    localparam int LATENCY_WIDTH    = 8;

    ////////////////////////////////////////////////////////////
    // types
    ////////////////////////////////////////////////////////////

    typedef logic [PC_WIDTH-1:0]       pc_t;
    typedef logic [CC_ID_BITS-1:0]     cc_id_t;

    // pc sits in the upper bits, window id in the lower ones
    typedef struct packed {
        pc_t    pc;
        cc_id_t cc_id;
    } pc_entry_t;

    typedef logic [INSTR_WIDTH-1:0]    instr_t;
    typedef logic [MEM_WIDTH-1:0]      mem_word_t;
    typedef logic [MEM_ADDR_WIDTH-1:0] mem_addr_t;
    typedef logic [LATENCY_WIDTH-1:0]  latency_t;
    typedef logic [N_CHARS-1:0]        char_mask_t;

endpackage

//--- hdl/fetch_engine.sv
////////////////////////////////////////////////////////////
// fetch engine top level with the input demux, window FIFOs,
// arbiter, fetch FSM, slot select, latency count and status
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module fetch_engine (
    input  logic                   clk,
    input  logic                   rst,
    input  engine_pkg::char_mask_t enable_chars,
    input  logic                   new_char,
    input  logic                   input_pc_valid,
    input  engine_pkg::pc_entry_t  input_pc_entry,
    output logic                   input_pc_ready,
    output engine_pkg::latency_t   input_pc_latency,
    output logic                   memory_valid,
    output engine_pkg::mem_addr_t  memory_addr,
    input  logic                   memory_ready,
    input  engine_pkg::mem_word_t  memory_data,
    output logic                   output_valid,
    output engine_pkg::pc_entry_t  output_pc_entry,
    output engine_pkg::instr_t     output_instr,
    input  logic                   output_ready,
    output logic                   full,
    output logic                   running,
    output engine_pkg::char_mask_t elaborating_chars
);

    // window FIFO side
    engine_pkg::char_mask_t fifo_wr, fifo_full, fifo_empty, fifo_valid, fifo_pop;
    engine_pkg::pc_entry_t  fifo_head [engine_pkg::N_CHARS];

    // arbiter to sequencer
    logic                  disp_valid, disp_ready;
    engine_pkg::pc_entry_t disp_entry;

    // sequencer to selector and the busy flag
    logic                   load_entry, load_instr, busy;
    engine_pkg::char_mask_t busy_mask;

    ////////////////////////////////////////////////////////////
    // input demux
    ////////////////////////////////////////////////////////////

    // only the addressed window sees the write
    always_comb
    begin
        fifo_wr = '0;
        fifo_wr[input_pc_entry.cc_id] = input_pc_valid;
    end

    assign input_pc_ready = !fifo_full[input_pc_entry.cc_id];

    // one queue per character window
    for (genvar i = 0; i < engine_pkg::N_CHARS; i++)
    begin : g_win
        pc_fifo #(.T(engine_pkg::pc_entry_t)) u_fifo (
            .clk   (clk),          .rst   (rst),
            .din   (input_pc_entry), .wr_en (fifo_wr[i]),     .full  (fifo_full[i]),
            .rd_en (fifo_pop[i]),    .dout  (fifo_head[i]),   .empty (fifo_empty[i]),
            .count ()
        );
    end

    assign fifo_valid = ~fifo_empty;

    ////////////////////////////////////////////////////////////
    // selection and fetch
    ////////////////////////////////////////////////////////////

    window_arbiter u_arb (
        .clk        (clk),        .rst          (rst),
        .in_valid   (fifo_valid), .enable_chars (enable_chars),
        .in_data    (fifo_head),  .pop          (fifo_pop),
        .shift      (new_char),   .disp_valid   (disp_valid),
        .disp_entry (disp_entry), .disp_ready   (disp_ready)
    );

    fetch_sequencer u_seq (
        .clk          (clk),          .rst          (rst),
        .disp_valid   (disp_valid),   .disp_ready   (disp_ready),
        .disp_pc      (disp_entry.pc),
        .memory_valid (memory_valid), .memory_addr  (memory_addr),
        .memory_ready (memory_ready),
        .load_entry   (load_entry),   .load_instr   (load_instr),
        .output_valid (output_valid), .output_ready (output_ready),
        .busy         (busy)
    );

    instr_select u_sel (
        .clk         (clk),
        .load_entry  (load_entry),  .disp_entry (disp_entry),
        .load_instr  (load_instr),  .memory_data (memory_data),
        .entry       (output_pc_entry), .instr  (output_instr)
    );

    // accepted inputs count up, dispatches count down
    latency_counter u_lat (
        .clk     (clk),
        .rst     (rst),
        .push    (input_pc_valid && input_pc_ready),
        .pop     (load_entry),
        .latency (input_pc_latency)
    );

    ////////////////////////////////////////////////////////////
    // status
    ////////////////////////////////////////////////////////////

    // window of the entry in flight
    always_comb
    begin
        busy_mask = '0;
        busy_mask[output_pc_entry.cc_id] = busy;
    end

    assign full              = |fifo_full;
    assign running           = |(fifo_valid & enable_chars) || busy;
    assign elaborating_chars = fifo_valid | busy_mask;

endmodule

//--- hdl/fetch_sequencer.sv
////////////////////////////////////////////////////////////
// fetch FSM, one entry at a time from dispatch to output
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module fetch_sequencer (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  disp_valid,
    output logic                  disp_ready,
    input  engine_pkg::pc_t       disp_pc,
    output logic                  memory_valid,
    output engine_pkg::mem_addr_t memory_addr,
    input  logic                  memory_ready,
    output logic                  load_entry,
    output logic                  load_instr,
    output logic                  output_valid,
    input  logic                  output_ready,
    output logic                  busy
);

    // IDLE waits for work, REQ holds the request, WAIT takes the data,
    // OUT holds the result
    typedef enum logic [1:0] {
        IDLE,
        REQ,
        WAIT,
        OUT
    } state_t;

    state_t state;
    state_t state_next;

    // word address latched at dispatch
    engine_pkg::mem_addr_t addr_q;

    ////////////////////////////////////////////////////////////
    // state register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= IDLE;
        end
        else
        begin
            state <= state_next;
        end
    end

    // upper pc bits select the memory word
    always_ff @(posedge clk)
    begin
        if (load_entry)
        begin
            addr_q <= disp_pc[engine_pkg::OFFSET_BITS +: engine_pkg::MEM_ADDR_WIDTH];
        end
    end

    ////////////////////////////////////////////////////////////
    // next state
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        state_next = state;
        case (state)
            IDLE: if (disp_valid)   state_next = REQ;
            REQ:  if (memory_ready) state_next = WAIT;
            // data returns exactly one cycle after acceptance
            WAIT: state_next = OUT;
            OUT:  if (output_ready) state_next = IDLE;
            default: state_next = IDLE;
        endcase
    end

    // outputs decoded from the state
    assign disp_ready   = (state == IDLE);
    assign load_entry   = disp_ready && disp_valid;
    assign memory_valid = (state == REQ);
    assign memory_addr  = addr_q;
    assign load_instr   = (state == WAIT);
    assign output_valid = (state == OUT);
    assign busy         = (state != IDLE);

endmodule

//--- hdl/instr_select.sv
////////////////////////////////////////////////////////////
// dispatched entry register and instruction slot select
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module instr_select (
    input  logic                  clk,
    input  logic                  load_entry,
    input  engine_pkg::pc_entry_t disp_entry,
    input  logic                  load_instr,
    input  engine_pkg::mem_word_t memory_data,
    output engine_pkg::pc_entry_t entry,
    output engine_pkg::instr_t    instr
);

    // slot of the instruction inside the memory word
    logic [engine_pkg::OFFSET_BITS-1:0] slot;

    // selected slice of the current memory word
    engine_pkg::instr_t slice;

    assign slot  = entry.pc[engine_pkg::OFFSET_BITS-1:0];
    assign slice = memory_data[slot * engine_pkg::INSTR_WIDTH +: engine_pkg::INSTR_WIDTH];

    // entry is held from dispatch until the next dispatch
    always_ff @(posedge clk)
    begin
        if (load_entry)
        begin
            entry <= disp_entry;
        end
    end

    // memory data is only valid on the load_instr cycle
    always_ff @(posedge clk)
    begin
        if (load_instr)
        begin
            instr <= slice;
        end
    end

endmodule

//--- hdl/latency_counter.sv
////////////////////////////////////////////////////////////
// queue occupancy count, reported as input latency
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module latency_counter (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 push,
    input  logic                 pop,
    output engine_pkg::latency_t latency
);

    // next value of the count
    engine_pkg::latency_t latency_next;

    always_comb
    begin
        case ({push, pop})
            // one entry queued
            2'b10:   latency_next = latency + 1'b1;
            // one entry handed to the sequencer
            2'b01:   latency_next = latency - 1'b1;
            // both or neither leave the occupancy unchanged
            default: latency_next = latency;
        endcase
    end

    // starts at 1 so an empty engine still reports one cycle
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            latency <= engine_pkg::latency_t'(1);
        end
        else
        begin
            latency <= latency_next;
        end
    end

endmodule

//--- hdl/pc_fifo.sv
////////////////////////////////////////////////////////////
// first-word-fall-through queue for one character window
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module pc_fifo #(
    parameter type T = engine_pkg::pc_entry_t
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  T                                      din,
    input  logic                                  wr_en,
    output logic                                  full,
    input  logic                                  rd_en,
    output T                                      dout,
    output logic                                  empty,
    output logic [engine_pkg::FIFO_COUNT_WIDTH-1:0] count
);

    // entry storage
    T mem [engine_pkg::FIFO_DEPTH];

    // pointers are one bit narrower than the count and wrap by themselves
    logic [engine_pkg::FIFO_COUNT_WIDTH-2:0] wr_ptr;
    logic [engine_pkg::FIFO_COUNT_WIDTH-2:0] rd_ptr;

    // accepted operations only
    logic do_write;
    logic do_read;

    assign do_write = wr_en && !full;
    assign do_read  = rd_en && !empty;

    // status from the occupancy count
    assign full  = (count == engine_pkg::FIFO_COUNT_WIDTH'(engine_pkg::FIFO_DEPTH));
    assign empty = (count == '0);

    // head is presented without a read request
    assign dout = mem[rd_ptr];

    // write side
    always_ff @(posedge clk)
    begin
        if (do_write)
        begin
            mem[wr_ptr] <= din;
        end
    end

    // pointers and occupancy
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_write)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // count only moves when exactly one side is active
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- hdl/window_arbiter.sv
////////////////////////////////////////////////////////////
// rotating fixed-priority arbiter over the window FIFO heads
// masked by enable_chars, rotated on every new character
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module window_arbiter (
    input  logic                   clk,
    input  logic                   rst,
    input  engine_pkg::char_mask_t in_valid,
    input  engine_pkg::char_mask_t enable_chars,
    input  engine_pkg::pc_entry_t  in_data [engine_pkg::N_CHARS],
    output engine_pkg::char_mask_t pop,
    input  logic                   shift,
    output logic                   disp_valid,
    output engine_pkg::pc_entry_t  disp_entry,
    input  logic                   disp_ready
);

    // lowest-priority window whose successor ranks first
    engine_pkg::cc_id_t lo_ptr;

    // requests surviving the enable mask
    engine_pkg::char_mask_t req;

    // winner of the current cycle
    engine_pkg::cc_id_t grant_idx;
    logic               found;

    assign req = in_valid & enable_chars;

    ////////////////////////////////////////////////////////////
    // priority pointer
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            // window 0 ranks first after reset
            lo_ptr <= engine_pkg::cc_id_t'(engine_pkg::N_CHARS - 1);
        end
        else if (shift)
        begin
            if (lo_ptr == engine_pkg::cc_id_t'(engine_pkg::N_CHARS - 1))
            begin
                lo_ptr <= '0;
            end
            else
            begin
                lo_ptr <= lo_ptr + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // grant search
    ////////////////////////////////////////////////////////////

    always_comb
    begin : grant_search
        int idx;
        found     = 1'b0;
        grant_idx = '0;
        // walk the ring starting just after the lowest-priority window
        for (int k = 1; k <= engine_pkg::N_CHARS; k++)
        begin
            idx = (int'(lo_ptr) + k) % engine_pkg::N_CHARS;
            if (!found && req[idx])
            begin
                found     = 1'b1;
                grant_idx = engine_pkg::cc_id_t'(idx);
            end
        end
    end

    assign disp_valid = found;
    assign disp_entry = in_data[grant_idx];

    // pop the granted head only when the sequencer takes it
    always_comb
    begin
        pop = '0;
        if (found && disp_ready)
        begin
            pop[grant_idx] = 1'b1;
        end
    end

endmodule

//--- test/mem_model.svh
////////////////////////////////////////////////////////////
// behavioral instruction memory for the testbench
// random ready, data one cycle after an accepted request
////////////////////////////////////////////////////////////

`ifndef MEM_MODEL_SVH
`define MEM_MODEL_SVH

// slot k of word a holds the tag and then pc a*4+k
function automatic engine_pkg::mem_word_t word_at(input engine_pkg::mem_addr_t addr);
    engine_pkg::mem_word_t w;
    w = '0;
    for (int k = 0; k < (1 << engine_pkg::OFFSET_BITS); k++)
    begin
        w[k*engine_pkg::INSTR_WIDTH +: engine_pkg::INSTR_WIDTH] =
            {INSTR_TAG, addr, engine_pkg::OFFSET_BITS'(k)};
    end
    return w;
endfunction

// request seen before the edge, answered on it
initial
begin : memory_proc
    logic                  take;
    engine_pkg::mem_addr_t addr;
    memory_ready = 1'b0;
    memory_data  = '0;
    void'($urandom(SEED));
    forever
    begin
        @(negedge clk);
        take = memory_valid && memory_ready;
        addr = memory_addr;
        @(posedge clk);
        if (take)
        begin
            memory_data <= word_at(addr);
        end
        // ready about two cycles out of three
        memory_ready <= (($urandom % 3) != 0);
    end
end

`endif

//--- test/tb_fetch_engine.sv
////////////////////////////////////////////////////////////
// fetch engine testbench with clock, reset, stimulus
// table, window model, scoreboard and output checks
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_fetch_engine;

    localparam logic [31:0] SEED      = 32'h84c7;
    localparam logic [7:0]  INSTR_TAG = 8'hC3;
    localparam int          N         = engine_pkg::N_CHARS;

    // table operations
    localparam logic [1:0] OP_PUSH = 2'd0;
    localparam logic [1:0] OP_CHAR = 2'd1;
    localparam logic [1:0] OP_RUN  = 2'd2;
    localparam logic [1:0] OP_FILL = 2'd3;

    typedef struct packed {
        logic [3:0] phase;
        logic [1:0] op;
        logic [1:0] cc;
        logic [7:0] pc;
        logic [3:0] en;
        logic [3:0] nchar;
        logic [3:0] ordy;
    } row_t;

    localparam int N_ROWS         = 26;
    localparam int TIMEOUT_CYCLES = 40 * N_ROWS;

    ////////////////////////////////////////////////////////////
    // stimulus table with phase, op, cc_id, pc, enable, pulses and ready pattern
    ////////////////////////////////////////////////////////////

    localparam row_t ROWS [N_ROWS] = '{
        // single fetch
        '{4'd1, OP_PUSH, 2'd1, 8'h2D, 4'h0, 4'd0, 4'hF},
        '{4'd1, OP_RUN,  2'd0, 8'h00, 4'hF, 4'd0, 4'hF},
        // priority with windows loaded while masked
        '{4'd2, OP_PUSH, 2'd3, 8'h41, 4'h0, 4'd0, 4'hF},
        '{4'd2, OP_PUSH, 2'd1, 8'h42, 4'h0, 4'd0, 4'hF},
        '{4'd2, OP_PUSH, 2'd2, 8'h47, 4'h0, 4'd0, 4'hF},
        '{4'd2, OP_PUSH, 2'd0, 8'h4A, 4'h0, 4'd0, 4'hF},
        '{4'd2, OP_PUSH, 2'd1, 8'h53, 4'h0, 4'd0, 4'hF},
        '{4'd2, OP_PUSH, 2'd0, 8'h5C, 4'h0, 4'd0, 4'hF},
        '{4'd2, OP_RUN,  2'd0, 8'h00, 4'hF, 4'd0, 4'hF},
        // rotation after two new characters
        '{4'd3, OP_CHAR, 2'd0, 8'h00, 4'h0, 4'd2, 4'hF},
        '{4'd3, OP_PUSH, 2'd0, 8'h61, 4'h0, 4'd0, 4'hF},
        '{4'd3, OP_PUSH, 2'd1, 8'h66, 4'h0, 4'd0, 4'hF},
        '{4'd3, OP_PUSH, 2'd2, 8'h6B, 4'h0, 4'd0, 4'hF},
        '{4'd3, OP_PUSH, 2'd3, 8'h70, 4'h0, 4'd0, 4'hF},
        '{4'd3, OP_RUN,  2'd0, 8'h00, 4'hF, 4'd0, 4'hF},
        // window 2 stays masked
        '{4'd4, OP_CHAR, 2'd0, 8'h00, 4'h0, 4'd1, 4'hF},
        '{4'd4, OP_PUSH, 2'd2, 8'h81, 4'h0, 4'd0, 4'hF},
        '{4'd4, OP_PUSH, 2'd2, 8'h82, 4'h0, 4'd0, 4'hF},
        '{4'd4, OP_PUSH, 2'd0, 8'h8D, 4'h0, 4'd0, 4'hF},
        '{4'd4, OP_PUSH, 2'd3, 8'h93, 4'h0, 4'd0, 4'hF},
        '{4'd4, OP_RUN,  2'd0, 8'h00, 4'hB, 4'd0, 4'hF},
        // back-pressure then a full window and the final drain
        '{4'd5, OP_PUSH, 2'd3, 8'hA4, 4'h0, 4'd0, 4'hF},
        '{4'd5, OP_PUSH, 2'd0, 8'hA9, 4'h0, 4'd0, 4'hF},
        '{4'd5, OP_RUN,  2'd0, 8'h00, 4'hB, 4'd0, 4'h8},
        '{4'd5, OP_FILL, 2'd1, 8'hC0, 4'h0, 4'd0, 4'hF},
        '{4'd5, OP_RUN,  2'd0, 8'h00, 4'hF, 4'd0, 4'hA}
    };

    // DUT ports
    logic                   clk, rst, new_char;
    logic                   input_pc_valid, input_pc_ready;
    logic                   memory_valid, memory_ready;
    logic                   output_valid, output_ready, full, running;
    engine_pkg::char_mask_t enable_chars, elaborating_chars;
    engine_pkg::pc_entry_t  input_pc_entry, output_pc_entry;
    engine_pkg::latency_t   input_pc_latency;
    engine_pkg::mem_addr_t  memory_addr;
    engine_pkg::mem_word_t  memory_data;
    engine_pkg::instr_t     output_instr;

    // window model, scoreboard and counters
    engine_pkg::pc_t       model_q [N][32];
    int                    model_n [N];
    int                    lo_model;
    engine_pkg::pc_entry_t expect_q [$];
    int accepted, outputs_seen, value_errors, other_errors, cycle_count, phase;

    // held output while output_ready is low
    logic                  hold_valid;
    engine_pkg::pc_entry_t hold_entry;
    engine_pkg::instr_t    hold_instr;

    fetch_engine u_dut (.*);

    `include "mem_model.svh"

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // stimulus tasks
    ////////////////////////////////////////////////////////////

    task automatic push_entry(input int cc, input int pc, input logic exp_ready);
        logic rdy;
        @(posedge clk);
        input_pc_valid <= 1'b1;
        input_pc_entry <= {engine_pkg::pc_t'(pc), engine_pkg::cc_id_t'(cc)};
        @(negedge clk);
        rdy = input_pc_ready;
        if (rdy !== exp_ready)
        begin
            value_errors++;
            $display("Fail %0t: ready for window %0d is %b, expected %b",
                     $time, cc, rdy, exp_ready);
        end
        // the model follows what the DUT actually took
        if (rdy === 1'b1)
        begin
            model_q[cc][model_n[cc]] = engine_pkg::pc_t'(pc);
            model_n[cc]++;
            accepted++;
        end
        @(posedge clk);
        input_pc_valid <= 1'b0;
    endtask

    task automatic check_ready(input int cc, input logic exp_ready);
        @(posedge clk);
        input_pc_entry <= {engine_pkg::pc_t'(0), engine_pkg::cc_id_t'(cc)};
        @(negedge clk);
        if (input_pc_ready !== exp_ready)
        begin
            value_errors++;
            $display("Fail %0t: idle ready for window %0d is %b", $time, cc, input_pc_ready);
        end
    endtask

    task automatic pulse_new_char(input int n);
        for (int i = 0; i < n; i++)
        begin
            @(posedge clk);
            new_char <= 1'b1;
            lo_model = (lo_model + 1) % N;
        end
        @(posedge clk);
        new_char <= 1'b0;
    endtask

    // status outputs against the window model
    task automatic check_status(input engine_pkg::char_mask_t exp_elab,
                                input logic                   exp_running);
        if (elaborating_chars !== exp_elab || running !== exp_running)
        begin
            value_errors++;
            $display("Fail %0t: status elaborating %b running %b, expected %b and %b",
                     $time, elaborating_chars, running, exp_elab, exp_running);
        end
    endtask

    // expected order walks the ring after the lowest-priority window one window at a time
    task automatic run_windows(input logic [3:0] en, input logic [3:0] ordy);
        int                     w;
        int                     cyc;
        engine_pkg::pc_entry_t  e;
        engine_pkg::char_mask_t pending;
        // windows holding entries before the first dispatch
        for (int i = 0; i < N; i++)
        begin
            pending[i] = (model_n[i] != 0);
        end
        for (int k = 1; k <= N; k++)
        begin
            w = (lo_model + k) % N;
            for (int i = 0; i < model_n[w] && en[w]; i++)
            begin
                e.pc    = model_q[w][i];
                e.cc_id = engine_pkg::cc_id_t'(w);
                expect_q.push_back(e);
            end
            if (en[w])
            begin
                model_n[w] = 0;
            end
        end
        enable_chars <= en;
        // nothing dispatched yet so the queued windows alone drive the status
        @(negedge clk);
        check_status(pending, |(pending & en));
        cyc = 0;
        while (expect_q.size() != 0)
        begin
            @(posedge clk);
            output_ready <= ordy[cyc % 4];
            cyc++;
        end
        @(negedge clk);
        for (int i = 0; i < N; i++)
        begin
            pending[i] = (model_n[i] != 0);
        end
        check_status(pending, |(pending & en));
        @(posedge clk);
        output_ready <= 1'b1;
    endtask

    task automatic fill_window(input int cc, input int pc);
        for (int i = 0; i < engine_pkg::FIFO_DEPTH; i++)
        begin
            push_entry(cc, pc + i, 1'b1);
        end
        @(negedge clk);
        if (full !== 1'b1)
        begin
            value_errors++;
            $display("Fail %0t: full is %b with window %0d filled", $time, full, cc);
        end
        check_ready(cc, 1'b0);
        check_ready((cc + 1) % N, 1'b1);
        // one more entry must be refused
        push_entry(cc, pc + engine_pkg::FIFO_DEPTH, 1'b0);
    endtask

    ////////////////////////////////////////////////////////////
    // output scoreboard sampled between clock edges
    ////////////////////////////////////////////////////////////

    always @(negedge clk)
    begin : output_monitor
        engine_pkg::pc_entry_t exp_entry;
        engine_pkg::latency_t  exp_latency;
        if (hold_valid && (!output_valid || output_pc_entry !== hold_entry ||
                           output_instr !== hold_instr))
        begin
            value_errors++;
            $display("Fail %0t: output moved while output_ready was low", $time);
        end
        hold_valid = 1'b0;
        if (!rst && output_valid && output_ready)
        begin
            if (expect_q.size() == 0)
            begin
                other_errors++;
                $display("unexpected output of pc %h from window %0d in phase %0d",
                         output_pc_entry.pc, output_pc_entry.cc_id, phase);
            end
            else
            begin
                exp_entry   = expect_q.pop_front();
                // one plus accepted minus dispatched with this entry included
                exp_latency = engine_pkg::latency_t'(1 + accepted - (outputs_seen + 1));
                if (output_pc_entry !== exp_entry)
                begin
                    value_errors++;
                    $display("Fail %0t: phase %0d entry %h, expected %h",
                             $time, phase, output_pc_entry, exp_entry);
                end
                if (output_instr !== {INSTR_TAG, exp_entry.pc})
                begin
                    value_errors++;
                    $display("Fail %0t: instruction %h for pc %h",
                             $time, output_instr, exp_entry.pc);
                end
                if (input_pc_latency !== exp_latency)
                begin
                    value_errors++;
                    $display("Fail %0t: latency %0d, expected %0d",
                             $time, input_pc_latency, exp_latency);
                end
                // the entry in flight keeps the engine running and its window marked
                if (running !== 1'b1 || elaborating_chars[exp_entry.cc_id] !== 1'b1)
                begin
                    value_errors++;
                    $display("Fail %0t: running %b elaborating %b with window %0d in flight",
                             $time, running, elaborating_chars, exp_entry.cc_id);
                end
            end
            outputs_seen++;
        end
        else if (!rst && output_valid)
        begin
            hold_valid = 1'b1;
            hold_entry = output_pc_entry;
            hold_instr = output_instr;
        end
    end

    // run limit
    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("timeout after %0d cycles, %0d outputs still expected",
                     cycle_count, expect_q.size());
            $display("errors: %0d value, %0d other", value_errors, other_errors);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial
    begin : stimulus
        rst            = 1'b1;
        enable_chars   = '0;
        new_char       = 1'b0;
        input_pc_valid = 1'b0;
        input_pc_entry = '0;
        output_ready   = 1'b1;
        hold_valid     = 1'b0;
        lo_model       = N - 1;
        accepted       = 0;
        outputs_seen   = 0;
        value_errors   = 0;
        other_errors   = 0;
        cycle_count    = 0;
        phase          = 0;
        for (int i = 0; i < N; i++)
        begin
            model_n[i] = 0;
        end
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        for (int r = 0; r < N_ROWS; r++)
        begin
            @(posedge clk);
            phase = ROWS[r].phase;
            enable_chars <= ROWS[r].en;
            case (ROWS[r].op)
                OP_PUSH: push_entry(ROWS[r].cc, ROWS[r].pc, 1'b1);
                OP_CHAR: pulse_new_char(ROWS[r].nchar);
                OP_RUN:  run_windows(ROWS[r].en, ROWS[r].ordy);
                default: fill_window(ROWS[r].cc, ROWS[r].pc);
            endcase
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        // everything accepted has been dispatched by now
        if (input_pc_latency !== engine_pkg::latency_t'(1 + accepted - outputs_seen))
        begin
            value_errors++;
            $display("Fail %0t: final latency %0d", $time, input_pc_latency);
        end
        $display("errors: %0d value, %0d other, %0d outputs, %0d inputs",
                 value_errors, other_errors, outputs_seen, accepted);
        if (value_errors + other_errors == 0)
        begin
            $display("ALL CHECKS PASSED");
        end
        else
        begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
